/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rr_replay
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* rr_cfg_pkg.sv */
// replay configuration package: channel count and per-channel trace widths
package rr_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // width table entries
  ////////////////////////////////////////////////////////////

  // one entry of a channel width table, widths up to 255 bits
  localparam int rr_width_bits = 8;

  typedef logic [rr_width_bits-1:0] rr_width_t;

  // largest channel count a width table can describe
  // tables of fewer channels are zero extended to this size
  localparam int rr_channel_max = 64;

  // full size table used by the width arithmetic helpers
  typedef rr_width_t [rr_channel_max-1:0] rr_width_table_t;

  ////////////////////////////////////////////////////////////
  // default replay configuration
  ////////////////////////////////////////////////////////////

  // number of replay channels, a power of two
  localparam int rr_channel_cnt_dflt = 4;

  // entry 0 is the lowest channel
  // ch0 8 bits, ch1 16 bits, ch2 8 bits, ch3 32 bits
  localparam rr_width_t [rr_channel_cnt_dflt-1:0] rr_channel_widths_dflt = {
    8'd32,
    8'd8,
    8'd16,
    8'd8
  };

  // 64 data bits in total for the default table
  // packed trace word is then 4 + 4 + 64 = 72 bits wide

endpackage

/* rr_replay_top.sv */
// replay top level: trace decoder with flat per-channel stream ports
module rr_replay_top #(
  parameter int CHANNEL_CNT = rr_cfg_pkg::rr_channel_cnt_dflt,
  parameter rr_cfg_pkg::rr_width_t [CHANNEL_CNT-1:0] CHANNEL_WIDTHS =
    rr_cfg_pkg::rr_channel_widths_dflt,
  localparam rr_cfg_pkg::rr_width_table_t WIDTH_TABLE =
    rr_cfg_pkg::rr_width_table_t'(CHANNEL_WIDTHS),
  localparam int DATA_WIDTH   = rr_stream_pkg::sum_width(WIDTH_TABLE, 0, CHANNEL_CNT),
  localparam int PACKED_WIDTH = rr_stream_pkg::packed_width(WIDTH_TABLE, CHANNEL_CNT)
) (
  input  logic                               clk,
  input  logic                               rstn,

  // packed trace words from the log reader
  input  logic                               in_valid,
  input  logic [PACKED_WIDTH-1:0]            in_data,
  output logic                               in_ready,

  // one stream per replay channel
  output logic [CHANNEL_CNT-1:0]             ch_valid,
  output logic [CHANNEL_CNT-1:0]             ch_logb_valid,
  output logic [CHANNEL_CNT*CHANNEL_CNT-1:0] ch_loge_valid,
  output logic [DATA_WIDTH-1:0]              ch_logb_data,
  input  logic [CHANNEL_CNT-1:0]             ch_ready
);

  ////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////

  rr_tracedecoder #(
    .CHANNEL_CNT    (CHANNEL_CNT),
    .CHANNEL_WIDTHS (CHANNEL_WIDTHS)
  ) u_decoder (
    .clk           (clk),
    .rstn          (rstn),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_ready      (in_ready),
    .ch_valid      (ch_valid),
    .ch_logb_valid (ch_logb_valid),
    .ch_loge_valid (ch_loge_valid),
    .ch_logb_data  (ch_logb_data),
    .ch_ready      (ch_ready)
  );

endmodule

/* rr_skid_buf.sv */
// two-entry skid buffer with registered output and registered in_ready
module rr_skid_buf #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rstn,

  // upstream side
  input  logic                  in_valid,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ready,

  // downstream side
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ready
);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // second entry, only fills while the output is stalled
  logic                  skid_valid;
  logic [DATA_WIDTH-1:0] skid_data;

  logic push;
  // main register may load this cycle
  logic main_free;

  assign push      = in_valid & in_ready;
  assign main_free = out_ready | ~out_valid;

  // ready is the inverted skid flag, so it comes straight from a flop
  // high out of reset, low only when both entries hold a word
  assign in_ready = ~skid_valid;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // skid word goes first, input can't push while skid is full
      out_valid  <= skid_valid | push;
      skid_valid <= 1'b0;
    end else if (push) begin
      // output stalled, park the new word
      skid_valid <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (push) begin
        out_data <= in_data;
      end
    end else if (push) begin
      skid_data <= in_data;
    end
  end

endmodule

/* rr_stream_pkg.sv */
// width arithmetic on channel width tables for packed trace streams
package rr_stream_pkg;

  ////////////////////////////////////////////////////////////
  // range sums
  ////////////////////////////////////////////////////////////

  // sum of table entries over the half-open range [lo, hi)
  // used at elaboration time for port and slice widths
  function automatic int sum_width(
    input rr_cfg_pkg::rr_width_table_t widths,
    input int                          lo,
    input int                          hi
  );
    int total;
    total = 0;
    for (int i = lo; i < hi; i++) begin
      total += int'(widths[i]);
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////
  // offsets and packed word size
  ////////////////////////////////////////////////////////////

  // bit offset of a channel inside the flat per-channel data bus
  // all lower channels sit below it, in channel order
  function automatic int chan_offset(
    input rr_cfg_pkg::rr_width_table_t widths,
    input int                          idx
  );
    return sum_width(widths, 0, idx);
  endfunction

  // packed input word: logb_valid, loge_valid, then the data area
  // the data area is sized for every channel being valid at once
  function automatic int packed_width(
    input rr_cfg_pkg::rr_width_table_t widths,
    input int                          cnt
  );
    int data_bits;
    data_bits = sum_width(widths, 0, cnt);
    return cnt * 2 + data_bits;
  endfunction

endpackage

/* rr_trace_demarshaller2.sv */
// demarshaller tree node: registers a packed trace word and splits it in two
module rr_trace_demarshaller2 #(
  parameter int CHANNEL_CNT = rr_cfg_pkg::rr_channel_cnt_dflt,
  parameter int LEFT_CNT    = CHANNEL_CNT / 2,
  parameter rr_cfg_pkg::rr_width_t [CHANNEL_CNT-1:0] CHANNEL_WIDTHS =
    rr_cfg_pkg::rr_channel_widths_dflt,
  parameter int LOGE_CNT    = CHANNEL_CNT,
  localparam rr_cfg_pkg::rr_width_table_t WIDTH_TABLE =
    rr_cfg_pkg::rr_width_table_t'(CHANNEL_WIDTHS),
  localparam int RIGHT_CNT   = CHANNEL_CNT - LEFT_CNT,
  localparam int FULL_WIDTH  = rr_stream_pkg::sum_width(WIDTH_TABLE, 0, CHANNEL_CNT),
  localparam int LEFT_WIDTH  = rr_stream_pkg::sum_width(WIDTH_TABLE, 0, LEFT_CNT),
  localparam int RIGHT_WIDTH = FULL_WIDTH - LEFT_WIDTH
) (
  input  logic                   clk,
  input  logic                   rstn,

  // packed word for this node's channels
  input  logic                   in_valid,
  input  logic [CHANNEL_CNT-1:0] in_logb_valid,
  input  logic [LOGE_CNT-1:0]    in_loge_valid,
  input  logic [FULL_WIDTH-1:0]  in_logb_data,
  output logic                   in_ready,

  // left side, lower channels
  output logic                   a_valid,
  output logic [LEFT_CNT-1:0]    a_logb_valid,
  output logic [LOGE_CNT-1:0]    a_loge_valid,
  output logic [LEFT_WIDTH-1:0]  a_logb_data,
  input  logic                   a_ready,

  // right side, upper channels
  output logic                   b_valid,
  output logic [RIGHT_CNT-1:0]   b_logb_valid,
  output logic [LOGE_CNT-1:0]    b_loge_valid,
  output logic [RIGHT_WIDTH-1:0] b_logb_data,
  input  logic                   b_ready
);

  localparam int WORD_WIDTH = FULL_WIDTH + LOGE_CNT + CHANNEL_CNT;
  // wide enough to hold any left data length, including all valid
  localparam int OFF_WIDTH  = $clog2(FULL_WIDTH + 1);

  // summed width of the valid left channels
  function automatic logic [OFF_WIDTH-1:0] left_len(input logic [LEFT_CNT-1:0] vld);
    logic [OFF_WIDTH-1:0] len;
    len = '0;
    for (int i = 0; i < LEFT_CNT; i++) begin
      if (vld[i]) begin
        len = len + OFF_WIDTH'(CHANNEL_WIDTHS[i]);
      end
    end
    return len;
  endfunction

  ////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////

  logic                   q_valid;
  logic [CHANNEL_CNT-1:0] q_logb_valid;
  logic [LOGE_CNT-1:0]    q_loge_valid;
  logic [FULL_WIDTH-1:0]  q_logb_data;
  logic                   q_ready;

  rr_skid_buf #(
    .DATA_WIDTH (WORD_WIDTH)
  ) u_in_buf (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_data   ({in_logb_data, in_loge_valid, in_logb_valid}),
    .in_ready  (in_ready),
    .out_valid (q_valid),
    .out_data  ({q_logb_data, q_loge_valid, q_logb_valid}),
    .out_ready (q_ready)
  );

  ////////////////////////////////////////////////////////////
  // partial acceptance
  ////////////////////////////////////////////////////////////

  // set once a side has taken the current word
  logic a_taken;
  logic b_taken;
  logic a_fire;
  logic b_fire;
  logic word_done;

  assign a_fire = a_valid & a_ready;
  assign b_fire = b_valid & b_ready;

  // a side that already took the word no longer holds it back
  assign q_ready   = (a_taken | a_ready) & (b_taken | b_ready);
  assign word_done = q_valid & q_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      a_taken <= 1'b0;
      b_taken <= 1'b0;
    end else if (word_done) begin
      // next word starts fresh on both sides
      a_taken <= 1'b0;
      b_taken <= 1'b0;
    end else begin
      if (a_fire) begin
        a_taken <= 1'b1;
      end
      if (b_fire) begin
        b_taken <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // split
  ////////////////////////////////////////////////////////////

  logic [FULL_WIDTH-1:0] right_shifted;

  // no resend to a side that already has this word
  assign a_valid = q_valid & ~a_taken;
  assign b_valid = q_valid & ~b_taken;

  // loge info is needed by every channel
  assign a_loge_valid = q_loge_valid;
  assign b_loge_valid = q_loge_valid;

  // left data always starts at bit zero
  assign a_logb_valid = q_logb_valid[LEFT_CNT-1:0];
  assign a_logb_data  = q_logb_data[LEFT_WIDTH-1:0];

  // right data follows the valid left fields only
  assign right_shifted = q_logb_data >> left_len(a_logb_valid);
  assign b_logb_valid  = q_logb_valid[CHANNEL_CNT-1:LEFT_CNT];
  assign b_logb_data   = right_shifted[RIGHT_WIDTH-1:0];

endmodule

/* rr_tracedecoder.sv */
// trace decoder: demarshaller tree from one packed stream to one stream per channel
module rr_tracedecoder #(
  parameter int CHANNEL_CNT = rr_cfg_pkg::rr_channel_cnt_dflt,
  parameter rr_cfg_pkg::rr_width_t [CHANNEL_CNT-1:0] CHANNEL_WIDTHS =
    rr_cfg_pkg::rr_channel_widths_dflt,
  localparam rr_cfg_pkg::rr_width_table_t WIDTH_TABLE =
    rr_cfg_pkg::rr_width_table_t'(CHANNEL_WIDTHS),
  localparam int DATA_WIDTH   = rr_stream_pkg::sum_width(WIDTH_TABLE, 0, CHANNEL_CNT),
  localparam int PACKED_WIDTH = rr_stream_pkg::packed_width(WIDTH_TABLE, CHANNEL_CNT)
) (
  input  logic                               clk,
  input  logic                               rstn,

  // packed trace stream
  input  logic                               in_valid,
  input  logic [PACKED_WIDTH-1:0]            in_data,
  output logic                               in_ready,

  // per-channel streams, bit i or slice i belongs to channel i
  output logic [CHANNEL_CNT-1:0]             ch_valid,
  output logic [CHANNEL_CNT-1:0]             ch_logb_valid,
  output logic [CHANNEL_CNT*CHANNEL_CNT-1:0] ch_loge_valid,
  output logic [DATA_WIDTH-1:0]              ch_logb_data,
  input  logic [CHANNEL_CNT-1:0]             ch_ready
);

  // levels of nodes, the leaf links sit one level below the last
  localparam int DEPTH    = $clog2(CHANNEL_CNT);
  // one link per tree edge plus the root link
  localparam int LINK_CNT = 2 * CHANNEL_CNT - 1;

  ////////////////////////////////////////////////////////////
  // link storage
  ////////////////////////////////////////////////////////////

  // valid, ready and loge copies are per link, heap order
  // link j of level l lives at index 2**l - 1 + j
  logic [LINK_CNT-1:0]                     lnk_valid;
  logic [LINK_CNT-1:0]                     lnk_ready;
  logic [LINK_CNT-1:0][CHANNEL_CNT-1:0]    lnk_loge_valid;

  // each level covers all channels exactly once
  // so logb_valid and data share one row per level at channel positions
  logic [DEPTH:0][CHANNEL_CNT-1:0]         lnk_logb_valid;
  logic [DEPTH:0][DATA_WIDTH-1:0]          lnk_logb_data;

  ////////////////////////////////////////////////////////////
  // root: unpack the input word
  ////////////////////////////////////////////////////////////

  // from lsb: logb_valid, loge_valid, packed data
  assign lnk_valid[0]      = in_valid;
  assign lnk_logb_valid[0] = in_data[CHANNEL_CNT-1:0];
  assign lnk_loge_valid[0] = in_data[CHANNEL_CNT +: CHANNEL_CNT];
  assign lnk_logb_data[0]  = in_data[2*CHANNEL_CNT +: DATA_WIDTH];
  assign in_ready          = lnk_ready[0];

  ////////////////////////////////////////////////////////////
  // demarshaller tree
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < DEPTH; l++) begin : g_lvl
    // channels per node at this level and per child
    localparam int G = CHANNEL_CNT >> l;
    localparam int H = G / 2;

    for (genvar j = 0; j < (1 << l); j++) begin : g_node
      localparam int IN_IDX = (1 << l) - 1 + j;
      localparam int A_IDX  = (2 << l) - 1 + 2 * j;
      localparam int B_IDX  = A_IDX + 1;
      // first channel of this node
      localparam int LO     = j * G;
      localparam int OFF    = rr_stream_pkg::chan_offset(WIDTH_TABLE, LO);
      localparam int W      = rr_stream_pkg::sum_width(WIDTH_TABLE, LO, LO + G);
      localparam int A_W    = rr_stream_pkg::sum_width(WIDTH_TABLE, LO, LO + H);
      localparam int B_W    = W - A_W;

      rr_trace_demarshaller2 #(
        .CHANNEL_CNT    (G),
        .LEFT_CNT       (H),
        .CHANNEL_WIDTHS (CHANNEL_WIDTHS[LO+G-1:LO]),
        .LOGE_CNT       (CHANNEL_CNT)
      ) u_node (
        .clk           (clk),
        .rstn          (rstn),
        .in_valid      (lnk_valid[IN_IDX]),
        .in_logb_valid (lnk_logb_valid[l][LO +: G]),
        .in_loge_valid (lnk_loge_valid[IN_IDX]),
        .in_logb_data  (lnk_logb_data[l][OFF +: W]),
        .in_ready      (lnk_ready[IN_IDX]),
        .a_valid       (lnk_valid[A_IDX]),
        .a_logb_valid  (lnk_logb_valid[l+1][LO +: H]),
        .a_loge_valid  (lnk_loge_valid[A_IDX]),
        .a_logb_data   (lnk_logb_data[l+1][OFF +: A_W]),
        .a_ready       (lnk_ready[A_IDX]),
        .b_valid       (lnk_valid[B_IDX]),
        .b_logb_valid  (lnk_logb_valid[l+1][LO+H +: H]),
        .b_loge_valid  (lnk_loge_valid[B_IDX]),
        .b_logb_data   (lnk_logb_data[l+1][OFF+A_W +: B_W]),
        .b_ready       (lnk_ready[B_IDX])
      );
    end
  end

  ////////////////////////////////////////////////////////////
  // leaves onto the flat channel ports
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CHANNEL_CNT; i++) begin : g_ch
    localparam int LEAF = CHANNEL_CNT - 1 + i;
    localparam int OFF  = rr_stream_pkg::chan_offset(WIDTH_TABLE, i);
    localparam int W    = int'(CHANNEL_WIDTHS[i]);

    assign ch_valid[i]      = lnk_valid[LEAF];
    assign ch_logb_valid[i] = lnk_logb_valid[DEPTH][i];
    // full loge copy per channel
    assign ch_loge_valid[i*CHANNEL_CNT +: CHANNEL_CNT] = lnk_loge_valid[LEAF];
    assign ch_logb_data[OFF +: W] = lnk_logb_data[DEPTH][OFF +: W];
    assign lnk_ready[LEAF]  = ch_ready[i];
  end

endmodule

/* sources.f */
rr_cfg_pkg.sv
rr_stream_pkg.sv
rr_skid_buf.sv
rr_trace_demarshaller2.sv
rr_tracedecoder.sv
rr_replay_top.sv
tb_rr_replay.sv

/* tb_rr_replay.sv */
// testbench for the replay trace decoder, packed words in and per-channel streams checked
module tb_rr_replay;
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // configuration and sizes
  ////////////////////////////////////////////////////////////

  // width of one channel's field, lowest channel is 0
  function automatic int chan_width(input int ch);
    return int'(rr_cfg_pkg::rr_channel_widths_dflt[ch]);
  endfunction

  // total data bits when every channel is valid
  function automatic int data_bits();
    int total;
    total = 0;
    for (int i = 0; i < rr_cfg_pkg::rr_channel_cnt_dflt; i++) begin
      total += chan_width(i);
    end
    return total;
  endfunction

  localparam int CH       = rr_cfg_pkg::rr_channel_cnt_dflt;
  localparam int DATA_W   = data_bits();
  localparam int PACKED_W = 2 * CH + DATA_W;
  // expected entry: field, logb_valid, loge copy
  localparam int ENTRY_W  = DATA_W + 1 + CH;

  localparam int FULL_WORDS   = 4;
  localparam int SPARSE_WORDS = 8;
  localparam int EMPTY_WORDS  = 2;
  // stalled channel 3 fills both entries of the two node buffers on its path
  localparam int STALL_FILL   = 4;
  localparam int STALL_WORDS  = 2 * STALL_FILL;
  localparam int RAND_WORDS   = 300;
  localparam int CYCLE_LIMIT  =
    20 * (FULL_WORDS + SPARSE_WORDS + EMPTY_WORDS + STALL_WORDS + RAND_WORDS) + 200;

  localparam logic [31:0] SEED = 32'h7b59e7e1;

  ////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////

  logic                 clk;
  logic                 rstn;
  logic                 in_valid;
  logic [PACKED_W-1:0]  in_data;
  logic                 in_ready;
  logic [CH-1:0]        ch_valid;
  logic [CH-1:0]        ch_logb_valid;
  logic [CH*CH-1:0]     ch_loge_valid;
  logic [DATA_W-1:0]    ch_logb_data;
  logic [CH-1:0]        ch_ready;

  rr_replay_top dut_i (
    .clk           (clk),
    .rstn          (rstn),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_ready      (in_ready),
    .ch_valid      (ch_valid),
    .ch_logb_valid (ch_logb_valid),
    .ch_loge_valid (ch_loge_valid),
    .ch_logb_data  (ch_logb_data),
    .ch_ready      (ch_ready)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference state and helpers
  ////////////////////////////////////////////////////////////

  // one queue of expected words per channel, input order
  logic [ENTRY_W-1:0] exp_q [CH][$];
  logic [31:0]        rng_state   = SEED;
  // separate stream for ready patterns
  logic [31:0]        ready_state = ~SEED;
  logic               rand_ready  = 1'b0;
  int                 err_cnt     = 0;
  int                 check_cnt   = 0;
  int                 test_cnt    = 0;
  int                 test_mark   = 0;
  int                 cycle_cnt   = 0;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // upper bits only, the low LCG bits repeat too soon
  function automatic logic [CH-1:0] rand_mask();
    logic [31:0] r;
    r = next_rand();
    return r[31 -: CH];
  endfunction

  function automatic logic [DATA_W-1:0] rand_field();
    return {next_rand(), next_rand()};
  endfunction

  // each channel ready about three cycles in four
  function automatic logic [CH-1:0] next_ready();
    ready_state = lcg_step(ready_state);
    return ready_state[31 -: CH] | ready_state[27 -: CH];
  endfunction

  // field position in the flat per-channel layout
  function automatic int chan_off(input int ch);
    int off;
    off = 0;
    for (int i = 0; i < ch; i++) begin
      off += chan_width(i);
    end
    return off;
  endfunction

  function automatic logic [DATA_W-1:0] field_mask(input int ch);
    return (DATA_W'(1) << chan_width(ch)) - DATA_W'(1);
  endfunction

  function automatic int pending_words();
    int total;
    total = 0;
    for (int i = 0; i < CH; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  task automatic report_value(input string name, input int ch,
                              input logic [DATA_W-1:0] want, input logic [DATA_W-1:0] got);
    err_cnt++;
    $display("Fail %s ch%0d: expected %h, got %h", name, ch, want, got);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_mark);
    test_mark = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // fields come in flat channel layout, only valid ones get packed
  task automatic send_word(input logic [CH-1:0] bv, input logic [CH-1:0] ev,
                           input logic [DATA_W-1:0] fields);
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] field;
    logic              taken;
    int                pos;
    data = '0;
    pos  = 0;
    for (int i = 0; i < CH; i++) begin
      field = (fields >> chan_off(i)) & field_mask(i);
      if (bv[i]) begin
        data |= field << pos;
        pos  += chan_width(i);
      end
    end
    in_valid = 1'b1;
    in_data  = {data, ev, bv};
    if (rand_ready) begin
      ch_ready = next_ready();
    end
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      #1;
      if (!taken && rand_ready) begin
        ch_ready = next_ready();
      end
    end
    // earliest channel output is two edges after acceptance
    for (int i = 0; i < CH; i++) begin
      exp_q[i].push_back({ev, bv[i], (fields >> chan_off(i)) & field_mask(i)});
    end
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    if (rand_ready) begin
      ch_ready = next_ready();
    end
  endtask

  // all readies high until every expected word is out
  task automatic wait_drain();
    rand_ready = 1'b0;
    ch_ready   = '1;
    do begin
      @(posedge clk);
      #1;
    end while (pending_words() != 0);
    assert (ch_valid == '0 && in_ready) else begin
      err_cnt++;
      $display("outputs not idle after all expected words were delivered");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output checking
  ////////////////////////////////////////////////////////////

  task automatic check_transfer(input int ch);
    logic [ENTRY_W-1:0] want;
    logic [DATA_W-1:0]  got_field;
    logic [CH-1:0]      got_loge;
    assert (exp_q[ch].size() != 0) else begin
      err_cnt++;
      $display("channel %0d delivered a word that was never sent", ch);
    end
    if (exp_q[ch].size() != 0) begin
      want      = exp_q[ch].pop_front();
      got_field = (ch_logb_data >> chan_off(ch)) & field_mask(ch);
      got_loge  = ch_loge_valid[ch*CH +: CH];
      check_cnt++;
      assert (ch_logb_valid[ch] == want[DATA_W]) else
        report_value("ch_logb_valid", ch, DATA_W'(want[DATA_W]), DATA_W'(ch_logb_valid[ch]));
      assert (got_loge == want[DATA_W+1 +: CH]) else
        report_value("ch_loge_valid", ch, DATA_W'(want[DATA_W+1 +: CH]), DATA_W'(got_loge));
      // data of a channel without logb is don't care
      if (want[DATA_W]) begin
        assert (got_field == want[DATA_W-1:0]) else
          report_value("ch_logb_data", ch, want[DATA_W-1:0], got_field);
      end
    end
  endtask

  // outputs sampled at the edge, before the DUT updates
  always @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < CH; i++) begin
        if (ch_valid[i] && ch_ready[i]) begin
          check_transfer(i);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [CH-1:0] sparse [8];
    logic [31:0]   r;
    sparse   = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0110, 4'b1001};
    rstn     = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    ch_ready = '1;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    assert (in_ready && ch_valid == '0) else begin
      err_cnt++;
      $display("after reset in_ready is not high or a channel output is valid");
    end
    finish_test("reset");

    for (int n = 0; n < FULL_WORDS; n++) begin
      send_word('1, rand_mask(), rand_field());
    end
    wait_drain();
    finish_test("full mask");

    for (int n = 0; n < SPARSE_WORDS; n++) begin
      send_word(sparse[n], rand_mask(), rand_field());
    end
    wait_drain();
    finish_test("sparse masks");

    for (int n = 0; n < EMPTY_WORDS; n++) begin
      send_word('0, rand_mask(), rand_field());
    end
    wait_drain();
    finish_test("empty mask");

    // top channel stalled, lower channels must keep moving
    ch_ready = {1'b0, {(CH-1){1'b1}}};
    for (int n = 0; n < STALL_FILL; n++) begin
      send_word(rand_mask(), rand_mask(), rand_field());
    end
    repeat (16) @(posedge clk);
    #1;
    assert (!in_ready) else begin
      err_cnt++;
      $display("input still ready while channel %0d is stalled", CH - 1);
    end
    assert (ch_valid[CH-1]) else begin
      err_cnt++;
      $display("stalled channel %0d is not offering its oldest word", CH - 1);
    end
    assert (exp_q[0].size() < exp_q[CH-1].size()) else begin
      err_cnt++;
      $display("channel 0 made no progress past the stalled channel");
    end
    ch_ready = '1;
    for (int n = 0; n < STALL_WORDS - STALL_FILL; n++) begin
      send_word(rand_mask(), rand_mask(), rand_field());
    end
    wait_drain();
    finish_test("stalled channel");

    rand_ready = 1'b1;
    for (int n = 0; n < RAND_WORDS; n++) begin
      r = next_rand();
      if (r[31:29] == 3'd0) begin
        idle_cycle();
      end
      send_word(rand_mask(), rand_mask(), rand_field());
    end
    wait_drain();
    finish_test("random traffic");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run limit from the stimulus length
  initial begin
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not complete", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
